// File: sim.f
common/fir_pkg.sv
common/fir_cfg_if.sv
config/fir_cfg_decode.sv
execute/fir_mac_engine.sv
source/fir_stream_out.sv
source/fir_top.sv
testbench/fir_assertions.sv
testbench/fir_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       ?= fir_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

# build the simulation executable
compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# exit status of the simulation is the pass or fail result
run: compile
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

// File: testbench/fir_tb.sv
module fir_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import fir_pkg::*;

    localparam int num_rows = 5;
    localparam int pat_ramp = 0;
    localparam int pat_alt = 1;
    localparam int pat_impulse = 2;
    localparam int pat_random = 3;

    // test table, one column per array
    string row_name [num_rows] = '{"ramp_full_ready", "alt_sign_backpressure",
                                   "impulse_full_ready", "random_backpressure",
                                   "short_random"};
    int row_len [num_rows] = '{20, 16, 12, 30, 5};
    int row_pattern [num_rows] = '{pat_ramp, pat_alt, pat_impulse, pat_random, pat_random};
    bit row_random_ready [num_rows] = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b1};

    logic axis_clk;
    logic axis_rst_n;
    logic awvalid;
    addr_t awaddr;
    logic wvalid;
    sample_t wdata;
    logic awready;
    logic wready;
    logic arvalid;
    addr_t araddr;
    logic arready;
    logic rvalid;
    logic rready;
    sample_t rdata;
    logic ss_tvalid;
    sample_t ss_tdata;
    logic ss_tready;
    logic sm_tvalid;
    logic sm_tready;
    sample_t sm_tdata;
    logic sm_tlast;

    int seed = 32'h8203;
    int cycle_count = 0;
    int cycle_limit;
    sample_t tap_vals [num_taps];
    sample_t samples [$];
    sample_t expected [$];

    fir_top fir_top_inst (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awvalid    (awvalid),
        .awaddr     (awaddr),
        .wvalid     (wvalid),
        .wdata      (wdata),
        .awready    (awready),
        .wready     (wready),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .arready    (arready),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .ss_tvalid  (ss_tvalid),
        .ss_tdata   (ss_tdata),
        .ss_tready  (ss_tready),
        .sm_tvalid  (sm_tvalid),
        .sm_tready  (sm_tready),
        .sm_tdata   (sm_tdata),
        .sm_tlast   (sm_tlast)
    );

    initial axis_clk = 1'b0;
    always #2 axis_clk = ~axis_clk;

    always @(posedge axis_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("SIMULATION FAILED");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic check_value(input string test, input string what,
                               input sample_t exp_val, input sample_t act_val);
        assert (act_val === exp_val) else begin
            $display("FAIL %s %s expected %h actual %h", test, what, exp_val, act_val);
            $display("SIMULATION FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    function automatic addr_t tap_addr(input int i);
        return addr_t'(reg_tap_base + 4 * i);
    endfunction

    task automatic lite_write(input addr_t a, input sample_t d);
        @(posedge axis_clk);
        awvalid <= 1'b1;
        awaddr <= a;
        wvalid <= 1'b1;
        wdata <= d;
        @(negedge axis_clk);
        while (!awready) @(negedge axis_clk);
        // write completes on this edge
        @(posedge axis_clk);
        awvalid <= 1'b0;
        wvalid <= 1'b0;
    endtask

    task automatic lite_read(input addr_t a, output sample_t d);
        @(posedge axis_clk);
        arvalid <= 1'b1;
        araddr <= a;
        @(negedge axis_clk);
        while (!arready) @(negedge axis_clk);
        @(posedge axis_clk);
        arvalid <= 1'b0;
        @(negedge axis_clk);
        while (!rvalid) @(negedge axis_clk);
        d = rdata;
        @(posedge axis_clk);
        rready <= 1'b1;
        @(posedge axis_clk);
        rready <= 1'b0;
    endtask

    task automatic make_taps(input int pattern);
        int rnd;
        for (int i = 0; i < num_taps; i++) begin
            rnd = $random(seed);
            case (pattern)
                pat_ramp: tap_vals[i] = sample_t'(i + 1);
                pat_alt: tap_vals[i] = sample_t'((i % 2 == 0) ? (i + 1) * 100 : -(i + 1) * 100);
                pat_impulse: tap_vals[i] = sample_t'((i == 4) ? 1 : 0);
                default: tap_vals[i] = rnd;
            endcase
        end
    endtask

    // convolution from zero history, kept to 32 bits
    task automatic build_expected(input int n);
        logic signed [63:0] sum;
        logic signed [63:0] coef;
        logic signed [63:0] smp;
        expected.delete();
        for (int k = 0; k < n; k++) begin
            sum = '0;
            for (int i = 0; i < num_taps; i++) begin
                if (k - i >= 0) begin
                    coef = tap_vals[i];
                    smp = samples[k - i];
                    sum = sum + coef * smp;
                end
            end
            expected.push_back(sum[31:0]);
        end
    endtask

    task automatic feed_samples(input int n);
        @(posedge axis_clk);
        for (int i = 0; i < n; i++) begin
            ss_tvalid <= 1'b1;
            ss_tdata <= samples[i];
            @(negedge axis_clk);
            while (!ss_tready) @(negedge axis_clk);
            @(posedge axis_clk);
        end
        ss_tvalid <= 1'b0;
    endtask

    task automatic collect_outputs(input int r);
        int count;
        int rnd;
        count = 0;
        while (count < row_len[r]) begin
            @(posedge axis_clk);
            rnd = $random(seed);
            sm_tready <= row_random_ready[r] ? rnd[0] : 1'b1;
            @(negedge axis_clk);
            // beat is taken on the coming edge
            if (sm_tvalid && sm_tready) begin
                check_value(row_name[r], $sformatf("output %0d data", count),
                            expected[count], sm_tdata);
                check_value(row_name[r], $sformatf("output %0d tlast", count),
                            32'(count == row_len[r] - 1), 32'(sm_tlast));
                count++;
            end
        end
        @(posedge axis_clk);
        sm_tready <= 1'b0;
    endtask

    task automatic run_row(input int r);
        sample_t rd;
        sample_t old_tap0;
        sample_t done_ctrl;
        int rnd;
        done_ctrl = '0;
        done_ctrl[ap_done_bit] = 1'b1;
        done_ctrl[ap_idle_bit] = 1'b1;
        make_taps(row_pattern[r]);
        for (int i = 0; i < num_taps; i++) begin
            lite_write(tap_addr(i), tap_vals[i]);
        end
        lite_write(reg_data_len, sample_t'(row_len[r]));
        for (int i = 0; i < num_taps; i++) begin
            lite_read(tap_addr(i), rd);
            check_value(row_name[r], $sformatf("tap %0d readback", i), tap_vals[i], rd);
        end
        lite_read(reg_data_len, rd);
        check_value(row_name[r], "data_len readback", sample_t'(row_len[r]), rd);
        samples.delete();
        for (int k = 0; k < row_len[r]; k++) begin
            rnd = $random(seed);
            samples.push_back(rnd);
        end
        build_expected(row_len[r]);
        old_tap0 = tap_vals[0];
        lite_write(reg_ap_ctrl, sample_t'(1 << ap_start_bit));
        // the tap write lands mid-run and must be dropped
        fork
            feed_samples(row_len[r]);
            collect_outputs(r);
            lite_write(tap_addr(0), ~old_tap0);
        join
        lite_read(reg_ap_ctrl, rd);
        check_value(row_name[r], "ap_ctrl after run", done_ctrl, rd);
        lite_read(tap_addr(0), rd);
        check_value(row_name[r], "tap 0 after busy write", old_tap0, rd);
        @(negedge axis_clk);
        check_value(row_name[r], "sm_tvalid after last beat", '0, 32'(sm_tvalid));
    endtask

    initial begin
        sample_t rd;
        sample_t idle_ctrl;
        cycle_limit = 0;
        for (int r = 0; r < num_rows; r++) begin
            cycle_limit += row_len[r] * (num_taps + 8) + 200;
        end
        axis_rst_n = 1'b0;
        awvalid = 1'b0;
        awaddr = '0;
        wvalid = 1'b0;
        wdata = '0;
        arvalid = 1'b0;
        araddr = '0;
        rready = 1'b0;
        ss_tvalid = 1'b0;
        ss_tdata = '0;
        sm_tready = 1'b0;
        repeat (5) @(posedge axis_clk);
        axis_rst_n <= 1'b1;

        idle_ctrl = '0;
        idle_ctrl[ap_idle_bit] = 1'b1;
        @(negedge axis_clk);
        check_value("after_reset", "sm_tvalid", '0, 32'(sm_tvalid));
        lite_read(reg_ap_ctrl, rd);
        check_value("after_reset", "ap_ctrl", idle_ctrl, rd);

        for (int r = 0; r < num_rows; r++) begin
            run_row(r);
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: testbench/fir_assertions.sv
module fir_assertions (
    input logic             axis_clk,
    input logic             axis_rst_n,
    input logic             awvalid,
    input logic             wvalid,
    input logic             awready,
    input logic             wready,
    input logic             rvalid,
    input logic             rready,
    input logic             sm_tvalid,
    input logic             sm_tready,
    input fir_pkg::sample_t sm_tdata
);
    timeunit 1ns;
    timeprecision 1ps;

    // a stalled output beat keeps valid and data
    property stalled_beat_holds;
        @(posedge axis_clk) disable iff (!axis_rst_n)
            sm_tvalid && !sm_tready |=> sm_tvalid && $stable(sm_tdata);
    endproperty

    // both readies rise together and only against a full write request
    property write_ready_paired;
        @(posedge axis_clk) disable iff (!axis_rst_n)
            (awready || wready) |-> awready && wready && awvalid && wvalid;
    endproperty

    property read_data_held;
        @(posedge axis_clk) disable iff (!axis_rst_n)
            rvalid && !rready |=> rvalid;
    endproperty

    assert property (stalled_beat_holds)
        else $error("sm_tdata or sm_tvalid changed while the beat was stalled");
    assert property (write_ready_paired)
        else $error("awready and wready differ or rose without a write request");
    assert property (read_data_held)
        else $error("rvalid dropped before rready");

endmodule

bind fir_top fir_assertions assertions_inst (
    .axis_clk   (axis_clk),
    .axis_rst_n (axis_rst_n),
    .awvalid    (awvalid),
    .wvalid     (wvalid),
    .awready    (awready),
    .wready     (wready),
    .rvalid     (rvalid),
    .rready     (rready),
    .sm_tvalid  (sm_tvalid),
    .sm_tready  (sm_tready),
    .sm_tdata   (sm_tdata)
);

// File: source/fir_top.sv
module fir_top (
    input  logic             axis_clk,
    input  logic             axis_rst_n,
    // axi-lite write
    input  logic             awvalid,
    input  fir_pkg::addr_t   awaddr,
    input  logic             wvalid,
    input  fir_pkg::sample_t wdata,
    output logic             awready,
    output logic             wready,
    // axi-lite read
    input  logic             arvalid,
    input  fir_pkg::addr_t   araddr,
    output logic             arready,
    output logic             rvalid,
    input  logic             rready,
    output fir_pkg::sample_t rdata,
    // sample stream in
    input  logic             ss_tvalid,
    input  fir_pkg::sample_t ss_tdata,
    output logic             ss_tready,
    // result stream out
    output logic             sm_tvalid,
    input  logic             sm_tready,
    output fir_pkg::sample_t sm_tdata,
    output logic             sm_tlast
);
    import fir_pkg::*;

    fir_cfg_if cfg_bus ();

    logic res_strobe;
    sample_t res_data;
    logic res_last;
    logic out_full;
    logic run_done;

    fir_cfg_decode cfg_decode_inst (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awvalid    (awvalid),
        .awaddr     (awaddr),
        .wvalid     (wvalid),
        .wdata      (wdata),
        .awready    (awready),
        .wready     (wready),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .arready    (arready),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .run_done   (run_done),
        .cfg        (cfg_bus.cfg)
    );

    fir_mac_engine mac_engine_inst (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .eng        (cfg_bus.engine),
        .ss_tvalid  (ss_tvalid),
        .ss_tdata   (ss_tdata),
        .ss_tready  (ss_tready),
        .out_full   (out_full),
        .res_strobe (res_strobe),
        .res_data   (res_data),
        .res_last   (res_last)
    );

    fir_stream_out stream_out_inst (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .res_strobe (res_strobe),
        .res_data   (res_data),
        .res_last   (res_last),
        .out_full   (out_full),
        .sm_tvalid  (sm_tvalid),
        .sm_tready  (sm_tready),
        .sm_tdata   (sm_tdata),
        .sm_tlast   (sm_tlast),
        .run_done   (run_done)
    );

endmodule

// File: source/fir_stream_out.sv
module fir_stream_out (
    input  logic             axis_clk,
    input  logic             axis_rst_n,
    input  logic             res_strobe,
    input  fir_pkg::sample_t res_data,
    input  logic             res_last,
    output logic             out_full,
    output logic             sm_tvalid,
    input  logic             sm_tready,
    output fir_pkg::sample_t sm_tdata,
    output logic             sm_tlast,
    output logic             run_done
);
    import fir_pkg::*;

    logic valid_q;
    logic last_q;
    sample_t data_q;
    logic xfer;

    assign xfer = valid_q && sm_tready;

    assign out_full = valid_q;
    assign sm_tvalid = valid_q;
    assign sm_tdata = data_q;
    assign sm_tlast = valid_q && last_q;

    // end of run is the accepted last beat
    assign run_done = xfer && last_q;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            valid_q <= 1'b0;
        end else if (res_strobe) begin
            valid_q <= 1'b1;
        end else if (xfer) begin
            valid_q <= 1'b0;
        end
    end

    // held stable under back-pressure
    always_ff @(posedge axis_clk) begin
        if (res_strobe) begin
            data_q <= res_data;
            last_q <= res_last;
        end
    end

endmodule

// File: execute/fir_mac_engine.sv
module fir_mac_engine (
    input  logic             axis_clk,
    input  logic             axis_rst_n,
    fir_cfg_if.engine        eng,
    input  logic             ss_tvalid,
    input  fir_pkg::sample_t ss_tdata,
    output logic             ss_tready,
    input  logic             out_full,
    output logic             res_strobe,
    output fir_pkg::sample_t res_data,
    output logic             res_last
);
    import fir_pkg::*;

    mac_state_t state;
    tap_idx_t coef_idx;
    len_t sample_cnt;
    logic busy;
    logic take_sample;
    logic last_tap;
    sample_t acc;
    // hist[0] is the newest sample
    sample_t hist [num_taps];

    assign ss_tready = (state == mac_wait_in);
    assign take_sample = ss_tready && ss_tvalid;
    assign last_tap = (coef_idx == tap_idx_t'(num_taps - 1));

    // hand-over waits while the output register is occupied
    assign res_strobe = (state == mac_hold) && !out_full;
    assign res_data = acc;
    assign res_last = (sample_cnt == eng.data_len);

    assign eng.coef_idx = coef_idx;
    assign eng.busy = busy;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state <= mac_idle;
            coef_idx <= '0;
            sample_cnt <= '0;
            busy <= 1'b0;
        end else begin
            case (state)
                mac_idle: begin
                    if (eng.start) begin
                        state <= mac_wait_in;
                        sample_cnt <= '0;
                        busy <= 1'b1;
                    end
                end
                mac_wait_in: begin
                    if (take_sample) begin
                        state <= mac_mac;
                        sample_cnt <= sample_cnt + 1'b1;
                    end
                end
                mac_mac: begin
                    // one tap per cycle
                    if (last_tap) begin
                        state <= mac_hold;
                        coef_idx <= '0;
                    end else begin
                        coef_idx <= coef_idx + 1'b1;
                    end
                end
                mac_hold: begin
                    if (!out_full) begin
                        if (res_last) begin
                            state <= mac_idle;
                            busy <= 1'b0;
                        end else begin
                            state <= mac_wait_in;
                        end
                    end
                end
                default: state <= mac_idle;
            endcase
        end
    end

    // history shift register, zeroed at run start
    always_ff @(posedge axis_clk) begin
        if ((state == mac_idle) && eng.start) begin
            for (int i = 0; i < num_taps; i++) begin
                hist[i] <= '0;
            end
        end else if (take_sample) begin
            hist[0] <= ss_tdata;
            for (int i = 1; i < num_taps; i++) begin
                hist[i] <= hist[i-1];
            end
        end
    end

    // single multiply-accumulate, result kept to 32 bits
    always_ff @(posedge axis_clk) begin
        if (take_sample) begin
            acc <= '0;
        end else if (state == mac_mac) begin
            acc <= acc + eng.coef * hist[coef_idx];
        end
    end

endmodule

// File: config/fir_cfg_decode.sv
module fir_cfg_decode (
    input  logic             axis_clk,
    input  logic             axis_rst_n,
    input  logic             awvalid,
    input  fir_pkg::addr_t   awaddr,
    input  logic             wvalid,
    input  fir_pkg::sample_t wdata,
    output logic             awready,
    output logic             wready,
    input  logic             arvalid,
    input  fir_pkg::addr_t   araddr,
    output logic             arready,
    output logic             rvalid,
    input  logic             rready,
    output fir_pkg::sample_t rdata,
    input  logic             run_done,
    fir_cfg_if.cfg           cfg
);
    import fir_pkg::*;

    lite_state_t state;
    logic wr_ack;
    logic wr_fire;
    logic cfg_open;
    logic start_q;
    logic ap_done;
    logic ap_idle;
    len_t data_len_q;
    sample_t taps [num_taps];
    sample_t rd_mux;
    sample_t rdata_q;

    // word-aligned address inside the tap window
    function automatic logic tap_hit(input addr_t a);
        addr_t off;
        off = a - reg_tap_base;
        return (a >= reg_tap_base) && (off[1:0] == 2'b00) &&
               (off[addr_width-1:2] < num_taps);
    endfunction

    function automatic tap_idx_t tap_of(input addr_t a);
        addr_t off;
        off = a - reg_tap_base;
        return tap_idx_t'(off >> 2);
    endfunction

    assign awready = wr_ack;
    assign wready = wr_ack;
    assign arready = (state == lite_read_wait);
    assign rvalid = (state == lite_read_resp);
    assign rdata = rdata_q;

    // write lands on the edge that closes the handshake
    assign wr_fire = wr_ack && awvalid && wvalid;
    // config registers are frozen during a run
    assign cfg_open = ap_idle && !cfg.busy;

    assign cfg.start = start_q;
    assign cfg.data_len = data_len_q;
    assign cfg.coef = taps[cfg.coef_idx];

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state <= lite_idle;
            wr_ack <= 1'b0;
        end else begin
            wr_ack <= 1'b0;
            case (state)
                lite_idle: begin
                    // reads win when both channels ask at once
                    if (!wr_ack) begin
                        if (arvalid) begin
                            state <= lite_read_wait;
                        end else if (awvalid && wvalid) begin
                            wr_ack <= 1'b1;
                        end
                    end
                end
                lite_read_wait: state <= lite_read_resp;
                lite_read_resp: begin
                    if (rready) begin
                        state <= lite_idle;
                    end
                end
                default: state <= lite_idle;
            endcase
        end
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            start_q <= 1'b0;
            ap_done <= 1'b0;
            ap_idle <= 1'b1;
            data_len_q <= '0;
        end else begin
            start_q <= 1'b0;
            if (wr_fire && (awaddr == reg_ap_ctrl) && wdata[ap_start_bit] && cfg_open) begin
                start_q <= 1'b1;
                ap_done <= 1'b0;
                ap_idle <= 1'b0;
            end else if (run_done) begin
                // sticky until the next start
                ap_done <= 1'b1;
                ap_idle <= 1'b1;
            end
            if (wr_fire && (awaddr == reg_data_len) && cfg_open) begin
                data_len_q <= len_t'(wdata);
            end
        end
    end

    // tap bank
    always_ff @(posedge axis_clk) begin
        if (wr_fire && cfg_open && tap_hit(awaddr)) begin
            taps[tap_of(awaddr)] <= wdata;
        end
    end

    // read data select, unmapped reads give zero
    always_comb begin
        rd_mux = '0;
        if (araddr == reg_ap_ctrl) begin
            rd_mux[ap_start_bit] = start_q;
            rd_mux[ap_done_bit] = ap_done;
            rd_mux[ap_idle_bit] = ap_idle;
        end else if (araddr == reg_data_len) begin
            rd_mux = sample_t'(data_len_q);
        end else if (tap_hit(araddr)) begin
            rd_mux = taps[tap_of(araddr)];
        end
    end

    // captured during the address handshake
    always_ff @(posedge axis_clk) begin
        if (state == lite_read_wait) begin
            rdata_q <= rd_mux;
        end
    end

endmodule

// File: common/fir_cfg_if.sv
interface fir_cfg_if;
    import fir_pkg::*;

    // one-cycle run start
    logic start;
    // samples per run
    len_t data_len;
    // coefficient lookup, index from the engine and value back
    tap_idx_t coef_idx;
    sample_t coef;
    // engine still has results to hand over
    logic busy;

    modport cfg (
        output start,
        output data_len,
        output coef,
        input  coef_idx,
        input  busy
    );

    modport engine (
        input  start,
        input  data_len,
        input  coef,
        output coef_idx,
        output busy
    );

endinterface

// File: common/fir_pkg.sv
package fir_pkg;

    // bus and datapath widths
    localparam int data_width = 32;
    localparam int addr_width = 12;

    // filter size
    localparam int num_taps = 11;
    localparam int tap_idx_width = $clog2(num_taps);

    typedef logic signed [data_width-1:0] sample_t;
    typedef logic [addr_width-1:0] addr_t;
    typedef logic [tap_idx_width-1:0] tap_idx_t;
    typedef logic [data_width-1:0] len_t;

    // register map, tap i lives at reg_tap_base + 4*i
    localparam addr_t reg_ap_ctrl = 12'h000;
    localparam addr_t reg_data_len = 12'h010;
    localparam addr_t reg_tap_base = 12'h020;

    // ap_ctrl bit positions
    localparam int ap_start_bit = 0;
    localparam int ap_done_bit = 1;
    localparam int ap_idle_bit = 2;

    // axi-lite slave states
    typedef enum logic [1:0] {
        lite_idle,
        lite_read_wait,
        lite_read_resp
    } lite_state_t;

    // mac engine states
    typedef enum logic [1:0] {
        mac_idle,
        mac_wait_in,
        mac_mac,
        mac_hold
    } mac_state_t;

endpackage
